//--- files.f
source/matrix_entry_pkg.sv
source/entry_parser.sv
source/matrix_store.sv
source/matrix_printer.sv
source/matrix_entry_top.sv
sim/matrix_entry_checker.sv
sim/output_monitor.sv
sim/tb_matrix_entry.sv

//--- run.sh
#!/bin/sh
# Compile and run the matrix entry testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_matrix_entry -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_matrix_entry)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

//--- sim/tb_matrix_entry.sv
// ==================================================
// Matrix entry engine testbench
// Clock, reset, byte stimulus, reference text and
// cycle limit
// ==================================================

`timescale 1ns/1ps

module tb_matrix_entry import matrix_entry_pkg::*; ();

    logic             clk = 1'b0;
    logic             rst_n;
    logic             rx_valid;
    logic             rx_ready;
    logic [7:0]       rx_data;
    logic             tx_valid;
    logic             tx_ready = 1'b1;
    logic [7:0]       tx_data;
    logic [dim_w-1:0] cfg_max_dim;
    logic [dim_w-1:0] cfg_max_value;
    err_code_t        error_code;

    logic       exp_push;
    logic [7:0] exp_byte;
    logic       err_check;
    err_code_t  err_expect;
    logic [2:0] test_id;
    logic       test_done;
    logic       summary;
    int         pending;
    int         error_total;

    logic   stall_on;
    integer seed   = 32'hf3c2_cb5d;
    int     cycles = 0;
    int     limit  = 0;
    string  exp_txt[6];

    always #10 clk = ~clk;

    // Random back-pressure on the transmit port
    always @(posedge clk) begin
        tx_ready <= !stall_on || (($random(seed) & 3) != 0);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Run stopped after %0d cycles, output never completed", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    matrix_entry_top u_matrix_entry_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_data      (rx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .cfg_max_dim  (cfg_max_dim),
        .cfg_max_value(cfg_max_value),
        .error_code   (error_code)
    );

    output_monitor u_monitor (
        .clk        (clk),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .error_code (error_code),
        .exp_push   (exp_push),
        .exp_byte   (exp_byte),
        .err_check  (err_check),
        .err_expect (err_expect),
        .test_id    (test_id),
        .test_done  (test_done),
        .summary    (summary),
        .pending    (pending),
        .error_total(error_total)
    );

    // ==================================================
    // Reference text and stimulus tasks
    // ==================================================
    // Row-major elements, one nibble each, element 0 lowest
    function automatic string expected_text(input int rows, input int cols,
                                            input logic [63:0] vals);
        string s;
        s = "";
        for (int r = 0; r < rows; r++) begin
            s = $sformatf("%s%c%c", s, 8'h0d, 8'h0a);
            for (int c = 0; c < cols; c++) begin
                if (c != 0) begin
                    s = {s, " "};
                end
                s = $sformatf("%s%c", s, 8'h30 + vals[4*(r*cols+c) +: 4]);
            end
        end
        return $sformatf("%s%c%c", s, 8'h0d, 8'h0a);
    endfunction

    task automatic push_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            exp_push <= 1'b1;
            exp_byte <= s[i];
            @(posedge clk);
        end
        exp_push <= 1'b0;
    endtask

    // Holds each byte until the receive handshake takes it
    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            rx_valid <= 1'b1;
            rx_data  <= s[i];
            @(negedge clk);
            while (!rx_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        rx_valid <= 1'b0;
    endtask

    task automatic wait_output();
        @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic check_error(input err_code_t code);
        err_expect <= code;
        err_check  <= 1'b1;
        @(posedge clk);
        err_check  <= 1'b0;
    endtask

    task automatic end_test();
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        rst_n         <= 1'b0;
        rx_valid      <= 1'b0;
        rx_data       <= 8'h00;
        cfg_max_dim   <= 4'd3;
        cfg_max_value <= 4'd8;
        exp_push      <= 1'b0;
        exp_byte      <= 8'h00;
        err_check     <= 1'b0;
        err_expect    <= err_none;
        test_id       <= 3'd0;
        test_done     <= 1'b0;
        summary       <= 1'b0;
        stall_on      <= 1'b0;

        exp_txt[0] = expected_text(2, 3, 64'h654321);
        exp_txt[1] = expected_text(2, 3, 64'h000321);
        exp_txt[2] = expected_text(2, 2, 64'h8765);
        exp_txt[3] = expected_text(2, 2, 64'h4321);
        exp_txt[4] = expected_text(2, 2, 64'h4321);
        exp_txt[5] = expected_text(3, 1, 64'h765);
        // Three alert bytes on top of the matrix text
        limit = 3;
        foreach (exp_txt[i]) begin
            limit += exp_txt[i].len();
        end
        limit = limit * 40 + 2000;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_id <= 3'd1;
        push_text(exp_txt[0]);
        send_text("2 3 1 2 3 4 5 6 ");
        wait_output();
        check_error(err_none);
        end_test();

        test_id <= 3'd2;
        push_text(exp_txt[1]);
        send_text("2 3 1 2 3F");
        wait_output();
        end_test();

        // Zero rows, then one row above the limit
        test_id <= 3'd3;
        push_text("!");
        send_text("0 2 ");
        wait_output();
        check_error(err_dim_range);
        push_text("!");
        send_text("4 2 ");
        wait_output();
        check_error(err_dim_range);
        push_text(exp_txt[2]);
        send_text("2 2 5 6 7 8 ");
        wait_output();
        check_error(err_none);
        end_test();

        test_id <= 3'd4;
        push_text({"!", exp_txt[3]});
        send_text("2 2 1 2 9");
        check_error(err_value_range);
        send_text(" 3 4 ");
        wait_output();
        check_error(err_none);
        end_test();

        test_id  <= 3'd5;
        stall_on <= 1'b1;
        push_text({exp_txt[4], exp_txt[5]});
        send_text("2 2 1 2 3 4 3 1 5 6 7 ");
        wait_output();
        stall_on <= 1'b0;
        check_error(err_none);
        end_test();

        summary <= 1'b1;
        @(posedge clk);
        summary <= 1'b0;
        @(negedge clk);
        if (error_total == 0 && u_matrix_entry_top.u_checker.assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim/output_monitor.sv
// ==================================================
// Transmit stream monitor
// Compares bytes and error codes, prints test results
// ==================================================

`timescale 1ns/1ps

module output_monitor import matrix_entry_pkg::*; (
    input  logic       clk,
    input  logic       tx_valid,
    input  logic       tx_ready,
    input  logic [7:0] tx_data,
    input  err_code_t  error_code,
    input  logic       exp_push,
    input  logic [7:0] exp_byte,
    input  logic       err_check,
    input  err_code_t  err_expect,
    input  logic [2:0] test_id,
    input  logic       test_done,
    input  logic       summary,
    output int         pending,
    output int         error_total
);

    logic [7:0] exp_q[$];
    int         exp_count   = 0;
    int         err_count   = 0;
    int         test_errors = 0;
    int         passed      = 0;
    int         failed      = 0;

    assign pending     = exp_count;
    assign error_total = err_count;

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd1: return "full_2x3";
            3'd2: return "finish_fill";
            3'd3: return "dim_range";
            3'd4: return "value_range";
            3'd5: return "back_to_back";
            default: return "idle";
        endcase
    endfunction

    always @(posedge clk) begin
        logic [7:0] want;
        if (exp_push) begin
            exp_q.push_back(exp_byte);
        end
        // ==================================================
        // Byte compare on each transfer
        // ==================================================
        if (tx_valid && tx_ready) begin
            if (exp_q.size() == 0) begin
                $display("Test %s sent byte 0x%02h when none was expected",
                         test_label(test_id), tx_data);
                test_errors++;
                err_count++;
            end else begin
                want = exp_q.pop_front();
                if (tx_data !== want) begin
                    $display("Error test %s expected 0x%02h actual 0x%02h",
                             test_label(test_id), want, tx_data);
                    test_errors++;
                    err_count++;
                end
            end
        end
        if (err_check && error_code !== err_expect) begin
            $display("Error test %s expected error code %0d actual %0d",
                     test_label(test_id), err_expect, error_code);
            test_errors++;
            err_count++;
        end
        if (test_done) begin
            if (exp_q.size() != 0) begin
                $display("Test %s ended with %0d bytes never transmitted",
                         test_label(test_id), exp_q.size());
                test_errors++;
                err_count++;
            end
            if (test_errors == 0) begin
                passed++;
                $display("Test %s passed", test_label(test_id));
            end else begin
                failed++;
                $display("Test %s failed with %0d errors", test_label(test_id), test_errors);
            end
            test_errors = 0;
        end
        if (summary) begin
            $display("Tests passed %0d failed %0d", passed, failed);
        end
        exp_count = exp_q.size();
    end

endmodule

//--- sim/matrix_entry_checker.sv
// ==================================================
// Concurrent assertions on the transmit handshake,
// store writes and the error code
// ==================================================

`timescale 1ns/1ps

module matrix_entry_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic [7:0] tx_data,
    input logic       matrix_valid,
    input logic       elem_valid,
    input logic [7:0] elem_data,
    input logic [3:0] error_code
);

    int assert_fails = 0;

    // Stalled byte stays on the port
    tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else begin
            $error("tx_valid or tx_data moved while tx_ready was low");
            assert_fails++;
        end

    // Element offered to a full store waits unchanged
    no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        matrix_valid && elem_valid |=> elem_valid && $stable(elem_data))
        else begin
            $error("element taken or changed while the store was full");
            assert_fails++;
        end

    err_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(error_code))
        else begin
            $error("error_code is unknown after reset");
            assert_fails++;
        end

endmodule

bind matrix_entry_top matrix_entry_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .tx_data     (tx_data),
    .matrix_valid(matrix_valid),
    .elem_valid  (elem_valid),
    .elem_data   (elem_data),
    .error_code  (error_code)
);

//--- source/matrix_entry_top.sv
// ==================================================
// Matrix entry engine top level
// Parser, element store and printer
// ==================================================

`timescale 1ns/1ps

module matrix_entry_top import matrix_entry_pkg::*; #(
    parameter int max_dim = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rx_valid,
    output logic             rx_ready,
    input  logic [7:0]       rx_data,
    output logic             tx_valid,
    input  logic             tx_ready,
    output logic [7:0]       tx_data,
    input  logic [dim_w-1:0] cfg_max_dim,
    input  logic [dim_w-1:0] cfg_max_value,
    output err_code_t        error_code
);

    localparam int addr_w = store_addr_w(max_dim);

    // Parser to store
    logic              elem_valid;
    logic              elem_ready;
    logic [elem_w-1:0] elem_data;
    logic              elem_last;
    logic [dim_w-1:0]  dim_m;
    logic [dim_w-1:0]  dim_n;
    logic              alert;

    // Store to printer
    logic               matrix_valid;
    logic [dim_w-1:0]   rows;
    logic [dim_w-1:0]   cols;
    logic [2*dim_w-1:0] rd_addr;
    logic [elem_w-1:0]  rd_data;
    logic               matrix_release;

    entry_parser #(
        .max_dim(max_dim)
    ) u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_data      (rx_data),
        .cfg_max_dim  (cfg_max_dim),
        .cfg_max_value(cfg_max_value),
        .elem_valid   (elem_valid),
        .elem_ready   (elem_ready),
        .elem_data    (elem_data),
        .elem_last    (elem_last),
        .dim_m        (dim_m),
        .dim_n        (dim_n),
        .alert        (alert),
        .error_code   (error_code)
    );

    matrix_store #(
        .max_dim(max_dim)
    ) u_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .elem_valid    (elem_valid),
        .elem_ready    (elem_ready),
        .elem_data     (elem_data),
        .elem_last     (elem_last),
        .dim_m         (dim_m),
        .dim_n         (dim_n),
        .matrix_valid  (matrix_valid),
        .rows          (rows),
        .cols          (cols),
        .rd_addr       (rd_addr[addr_w-1:0]),
        .rd_data       (rd_data),
        .matrix_release(matrix_release)
    );

    matrix_printer u_printer (
        .clk           (clk),
        .rst_n         (rst_n),
        .alert         (alert),
        .matrix_valid  (matrix_valid),
        .rows          (rows),
        .cols          (cols),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .matrix_release(matrix_release),
        .tx_valid      (tx_valid),
        .tx_ready      (tx_ready),
        .tx_data       (tx_data)
    );

endmodule

//--- source/matrix_printer.sv
// ==================================================
// Matrix printer
// Formats stored rows and alert echoes into the
// transmit byte stream
// ==================================================

`timescale 1ns/1ps

module matrix_printer import matrix_entry_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alert,
    input  logic               matrix_valid,
    input  logic [dim_w-1:0]   rows,
    input  logic [dim_w-1:0]   cols,
    output logic [2*dim_w-1:0] rd_addr,
    input  logic [elem_w-1:0]  rd_data,
    output logic               matrix_release,
    output logic               tx_valid,
    input  logic               tx_ready,
    output logic [7:0]         tx_data
);

    localparam logic [3:0] s_idle   = 4'd0;
    localparam logic [3:0] s_cr     = 4'd1;
    localparam logic [3:0] s_lf     = 4'd2;
    localparam logic [3:0] s_read   = 4'd3;
    localparam logic [3:0] s_wait   = 4'd4;
    localparam logic [3:0] s_digit  = 4'd5;
    localparam logic [3:0] s_sep    = 4'd6;
    localparam logic [3:0] s_end_cr = 4'd7;
    localparam logic [3:0] s_end_lf = 4'd8;
    localparam logic [3:0] s_done   = 4'd9;

    logic [3:0]       step;
    logic [dim_w-1:0] row;
    logic [dim_w-1:0] col;
    logic             alert_pend;
    logic             tx_free;

    // Output register can take a new byte
    assign tx_free = !tx_valid || tx_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step           <= s_idle;
            row            <= '0;
            col            <= '0;
            alert_pend     <= 1'b0;
            tx_valid       <= 1'b0;
            matrix_release <= 1'b0;
        end else begin
            matrix_release <= 1'b0;
            if (tx_ready) begin
                tx_valid <= 1'b0;
            end

            case (step)
                s_idle: begin
                    // Alerts go out only between matrices
                    if (alert_pend && tx_free) begin
                        tx_valid   <= 1'b1;
                        tx_data    <= char_alert;
                        alert_pend <= 1'b0;
                    end else if (matrix_valid && !matrix_release && !alert_pend) begin
                        row  <= '0;
                        col  <= '0;
                        step <= s_cr;
                    end
                end
                s_cr, s_end_cr: begin
                    if (tx_free) begin
                        tx_valid <= 1'b1;
                        tx_data  <= char_cr;
                        step     <= (step == s_cr) ? s_lf : s_end_lf;
                    end
                end
                s_lf, s_end_lf: begin
                    if (tx_free) begin
                        tx_valid <= 1'b1;
                        tx_data  <= char_lf;
                        step     <= (step == s_lf) ? s_read : s_done;
                    end
                end
                s_read: begin
                    rd_addr <= row * cols + col;
                    step    <= s_wait;
                end
                // Store read latency
                s_wait: step <= s_digit;
                s_digit: begin
                    if (tx_free) begin
                        tx_valid <= 1'b1;
                        tx_data  <= rd_data + char_zero;
                        if (col != cols - 1'b1) begin
                            step <= s_sep;
                        end else if (row != rows - 1'b1) begin
                            row  <= row + 1'b1;
                            col  <= '0;
                            step <= s_cr;
                        end else begin
                            step <= s_end_cr;
                        end
                    end
                end
                s_sep: begin
                    if (tx_free) begin
                        tx_valid <= 1'b1;
                        tx_data  <= char_space;
                        col      <= col + 1'b1;
                        step     <= s_read;
                    end
                end
                // Hand the store back once the last LF has left
                s_done: begin
                    if (tx_valid && tx_ready) begin
                        matrix_release <= 1'b1;
                        step           <= s_idle;
                    end
                end
                default: step <= s_idle;
            endcase

            if (alert) begin
                alert_pend <= 1'b1;
            end
        end
    end

endmodule

//--- source/matrix_store.sv
// ==================================================
// Matrix element store
// Write counter, full flag, latched dimensions and a
// registered read port
// ==================================================

`timescale 1ns/1ps

module matrix_store import matrix_entry_pkg::*; #(
    parameter int max_dim = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             elem_valid,
    output logic                             elem_ready,
    input  logic [elem_w-1:0]                elem_data,
    input  logic                             elem_last,
    input  logic [dim_w-1:0]                 dim_m,
    input  logic [dim_w-1:0]                 dim_n,
    output logic                             matrix_valid,
    output logic [dim_w-1:0]                 rows,
    output logic [dim_w-1:0]                 cols,
    input  logic [store_addr_w(max_dim)-1:0] rd_addr,
    output logic [elem_w-1:0]                rd_data,
    input  logic                             matrix_release
);

    localparam int depth  = max_dim * max_dim;
    localparam int addr_w = store_addr_w(max_dim);

    logic [elem_w-1:0] mem [depth];
    logic [addr_w-1:0] wr_cnt;
    logic              full;
    logic              wr_fire;

    assign elem_ready   = !full;
    assign matrix_valid = full;
    assign wr_fire      = elem_valid && elem_ready;

    // Storage and read port
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_cnt] <= elem_data;
        end
        rd_data <= mem[rd_addr];
        if (wr_fire && elem_last) begin
            rows <= dim_m;
            cols <= dim_n;
        end
    end

    // Fill tracking, full until the printer lets go
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
            full   <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_cnt <= elem_last ? '0 : wr_cnt + 1'b1;
            end
            if (wr_fire && elem_last) begin
                full <= 1'b1;
            end else if (matrix_release) begin
                full <= 1'b0;
            end
        end
    end

endmodule

//--- source/entry_parser.sv
// ==================================================
// Byte-stream parser for matrix entry
// Dimension and value range checks, zero fill on 'F'
// ==================================================

`timescale 1ns/1ps

module entry_parser import matrix_entry_pkg::*; #(
    parameter int max_dim = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx_valid,
    output logic              rx_ready,
    input  logic [7:0]        rx_data,
    input  logic [dim_w-1:0]  cfg_max_dim,
    input  logic [dim_w-1:0]  cfg_max_value,
    output logic              elem_valid,
    input  logic              elem_ready,
    output logic [elem_w-1:0] elem_data,
    output logic              elem_last,
    output logic [dim_w-1:0]  dim_m,
    output logic [dim_w-1:0]  dim_n,
    output logic              alert,
    output err_code_t         error_code
);

    localparam int cnt_w = $clog2(max_dim * max_dim + 1);

    localparam logic [1:0] st_rows = 2'd0;
    localparam logic [1:0] st_cols = 2'd1;
    localparam logic [1:0] st_data = 2'd2;
    localparam logic [1:0] st_fill = 2'd3;

    logic [1:0]         state;
    logic [elem_w-1:0]  acc;
    logic               have_digit;
    logic [elem_w-1:0]  rows_val;
    logic [cnt_w-1:0]   total;
    logic [cnt_w-1:0]   count;

    logic               rx_fire;
    logic               can_issue;
    logic               is_digit;
    logic [3:0]         digit;
    logic [elem_w+3:0]  acc_wide;
    logic [elem_w-1:0]  acc_next;
    logic [2*dim_w-1:0] dim_product;
    logic               last_next;

    // Side must be nonzero and fit both the runtime limit and the store
    function automatic logic dim_ok(input logic [elem_w-1:0] v,
                                    input logic [dim_w-1:0] limit);
        return (v != '0) && (v <= elem_w'(limit)) && (v <= elem_w'(max_dim));
    endfunction

    // ==================================================
    // Byte decode
    // ==================================================
    assign can_issue = !elem_valid || elem_ready;
    assign rx_ready  = can_issue && (state != st_fill);
    assign rx_fire   = rx_valid && rx_ready;
    assign is_digit  = (rx_data >= char_zero) && (rx_data <= char_zero + 8'd9);
    assign digit     = rx_data[3:0];

    // Saturate so oversized numbers never wrap into range
    assign acc_wide = acc * 10 + digit;
    assign acc_next = (|acc_wide[elem_w+3:elem_w]) ? '1 : acc_wide[elem_w-1:0];

    assign dim_product = rows_val[dim_w-1:0] * acc[dim_w-1:0];
    assign last_next   = (count + 1'b1) == total;

    // ==================================================
    // Parse FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_rows;
            acc        <= '0;
            have_digit <= 1'b0;
            count      <= '0;
            elem_valid <= 1'b0;
            elem_last  <= 1'b0;
            alert      <= 1'b0;
            error_code <= err_none;
        end else begin
            alert <= 1'b0;
            if (elem_valid && elem_ready) begin
                elem_valid <= 1'b0;
            end

            case (state)
                st_rows, st_cols: begin
                    if (rx_fire) begin
                        if (is_digit) begin
                            acc        <= acc_next;
                            have_digit <= 1'b1;
                            error_code <= err_none;
                        end else if (rx_data == char_space) begin
                            if (have_digit) begin
                                acc        <= '0;
                                have_digit <= 1'b0;
                                if (state == st_rows) begin
                                    rows_val <= acc;
                                    state    <= st_cols;
                                end else if (dim_ok(rows_val, cfg_max_dim) &&
                                             dim_ok(acc, cfg_max_dim)) begin
                                    dim_m      <= rows_val[dim_w-1:0];
                                    dim_n      <= acc[dim_w-1:0];
                                    total      <= cnt_w'(dim_product);
                                    count      <= '0;
                                    error_code <= err_none;
                                    state      <= st_data;
                                end else begin
                                    // Bad size, start over at the row count
                                    error_code <= err_dim_range;
                                    alert      <= 1'b1;
                                    state      <= st_rows;
                                end
                            end
                        end else begin
                            error_code <= err_dim_range;
                            alert      <= 1'b1;
                        end
                    end
                end

                st_data: begin
                    if (rx_fire) begin
                        if (is_digit) begin
                            if (error_code != err_none) begin
                                // Recovery needs a fresh single digit in range
                                if (digit <= cfg_max_value) begin
                                    acc        <= elem_w'(digit);
                                    have_digit <= 1'b1;
                                    error_code <= err_none;
                                end else begin
                                    alert <= 1'b1;
                                end
                            end else if (acc_next > elem_w'(cfg_max_value)) begin
                                error_code <= err_value_range;
                                alert      <= 1'b1;
                            end else begin
                                acc        <= acc_next;
                                have_digit <= 1'b1;
                            end
                        end else if (rx_data == char_space || rx_data == char_finish) begin
                            if (error_code == err_none) begin
                                acc        <= '0;
                                have_digit <= 1'b0;
                                if (have_digit) begin
                                    elem_valid <= 1'b1;
                                    elem_data  <= acc;
                                    elem_last  <= last_next;
                                    count      <= count + 1'b1;
                                end
                                if (have_digit && last_next) begin
                                    state <= st_rows;
                                end else if (rx_data == char_finish) begin
                                    state <= st_fill;
                                end
                            end
                        end else begin
                            error_code <= err_value_range;
                            alert      <= 1'b1;
                        end
                    end
                end

                // One zero per accepted slot until the matrix is complete
                default: begin
                    if (can_issue) begin
                        elem_valid <= 1'b1;
                        elem_data  <= '0;
                        elem_last  <= last_next;
                        count      <= count + 1'b1;
                        if (last_next) begin
                            state <= st_rows;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- source/matrix_entry_pkg.sv
// ==================================================
// Shared widths, ASCII byte codes, store address
// sizing and the error code of the matrix entry engine
// ==================================================

package matrix_entry_pkg;

    // Data widths
    localparam int elem_w = 8;
    localparam int dim_w  = 4;

    // ASCII codes seen on the byte streams
    localparam logic [7:0] char_space  = 8'h20;
    localparam logic [7:0] char_finish = 8'h46;
    localparam logic [7:0] char_cr     = 8'h0d;
    localparam logic [7:0] char_lf     = 8'h0a;
    localparam logic [7:0] char_alert  = 8'h21;
    localparam logic [7:0] char_zero   = 8'h30;

    // Status reported to the host
    typedef enum logic [3:0] {
        err_none        = 4'd0,
        err_dim_range   = 4'd1,
        err_value_range = 4'd2
    } err_code_t;

    // Address bits for a square store of the given side
    function automatic int store_addr_w(input int side);
        return (side > 1) ? $clog2(side * side) : 1;
    endfunction

endpackage
